//--- insn_decode_class.svh
`ifndef INSN_DECODE_CLASS_SVH
`define INSN_DECODE_CLASS_SVH

// Match patterns for casez on a full instruction word.

// Swap, word or byte, with the fixed 1001 marker in bits 7:4.
`define DECODE_SWP 32'b????_0001_0?00_????_????_0000_1001_????

// Single word or byte load and store, immediate or register offset.
`define DECODE_LDRSTR 32'b????_01??_????_????_????_????_????_????

// Block load and store.
`define DECODE_LDMSTM 32'b????_100?_????_????_????_????_????_????

// Coprocessor register transfer; bit 4 set tells it apart from CDP.
`define DECODE_MRCMCR 32'b????_1110_????_????_????_????_???1_????

`endif

//--- arm_mem_pkg.sv
`default_nettype none

package arm_mem_pkg;

	// Cycles that rw_wait stays high at the start of each new bus request.
	localparam int MEM_WAIT = 1;

	// The system coprocessor answers to this number only.
	localparam logic [3:0] CP_OWN_NUM = 4'd15;

	// Register number that routes an MRC result or an S-bit LDM to the status word.
	localparam logic [3:0] PC_REG = 4'd15;

	// Condition flags within a status word.
	localparam int FLAGS_MSB = 31;
	localparam int FLAGS_LSB = 28;

	// Coprocessor number within the low twelve instruction bits.
	localparam int CP_NUM_MSB = 11;
	localparam int CP_NUM_LSB = 8;

	// Address step of one word in a block transfer.
	localparam logic [5:0] WORD_STEP = 6'd4;

	localparam int RAM_ADDR_BITS = 8;
	localparam int RAM_WORDS = 1 << RAM_ADDR_BITS;

	// Sequencer states of single transfers and swaps.
	localparam logic SEQ_FIRST = 1'b0;
	localparam logic SEQ_SECOND = 1'b1;

	// Sequencer states of block transfers.
	localparam logic [1:0] BLK_SETUP = 2'd0;
	localparam logic [1:0] BLK_XFER = 2'd1;
	localparam logic [1:0] BLK_BASE = 2'd2;

	// LDR/STR, SWP and MCR/MRC share this layout; for MCR/MRC, rn holds CRn.
	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  class_bits;
		logic        p;
		logic        u;
		logic        b;
		logic        w;
		logic        l;
		logic [3:0]  rn;
		logic [3:0]  rd;
		logic [11:0] offset;
	} single_xfer_t;

	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  class_bits;
		logic        p;
		logic        u;
		logic        s;
		logic        w;
		logic        l;
		logic [3:0]  rn;
		logic [15:0] reg_list;
	} block_xfer_t;

	typedef union packed {
		single_xfer_t single_view;
		block_xfer_t  block_view;
	} insn_word_t;

endpackage

`default_nettype wire

//--- load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align (
	input  wire [31:0]  rd_data,
	input  wire [1:0]   byte_addr,
	input  wire         byte_sel,
	output logic [31:0] aligned
);

	logic [31:0] rot_half;
	logic [31:0] rot_byte;

	// Rotate right so the addressed byte lands in bits 7:0.
	assign rot_half = byte_addr[1] ? {rd_data[15:0], rd_data[31:16]} : rd_data;
	assign rot_byte = byte_addr[0] ? {rot_half[7:0], rot_half[31:8]} : rot_half;

	// Byte loads are zero extended.
	assign aligned = byte_sel ? {24'd0, rot_byte[7:0]} : rot_byte;

endmodule

`default_nettype wire

//--- reg_list_walker.sv
`timescale 1ns/1ns
`default_nettype none

module reg_list_walker (
	input  wire         clk,
	input  wire         reset,
	input  wire         start,
	input  wire         step,
	input  wire         descending,
	input  wire         pre_index,
	input  wire [15:0]  reg_list,
	output logic [3:0]  cur_reg,
	output logic [5:0]  offset,
	output logic        last
);
	import arm_mem_pkg::*;

	logic [15:0] pending;
	logic [15:0] mirrored;
	logic [5:0]  done_off;
	logic [3:0]  low_idx;

	// Mirroring lets a descending walk reuse the lowest-first search.
	always_comb begin
		for (int i = 0; i < 16; i++)
			mirrored[i] = reg_list[15 - i];
	end

	always_comb begin
		low_idx = 4'd0;
		for (int i = 15; i >= 0; i--) begin
			if (pending[i])
				low_idx = 4'(i);
		end
	end

	assign cur_reg = descending ? 4'd15 - low_idx : low_idx;
	assign offset = pre_index ? done_off + WORD_STEP : done_off;
	assign last = (pending & (pending - 16'd1)) == 16'd0;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 16'd0;
			done_off <= 6'd0;
		end else if (start) begin
			pending <= descending ? mirrored : reg_list;
			done_off <= 6'd0;
		end else if (step) begin
			pending <= pending & (pending - 16'd1);
			done_off <= done_off + WORD_STEP;
		end
	end

endmodule

`default_nettype wire

//--- data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram (
	input  wire         clk,
	input  wire         reset,
	input  wire [31:0]  busaddr,
	input  wire         rd_req,
	input  wire         wr_req,
	input  wire [31:0]  wr_data,
	output logic [31:0] rd_data,
	output logic        rw_wait
);
	import arm_mem_pkg::*;

	logic [31:0]              mem [RAM_WORDS];
	logic [3:0]               wait_cnt;
	logic                     req;
	logic [RAM_ADDR_BITS-1:0] word_addr;

	assign req = rd_req | wr_req;
	assign word_addr = busaddr[RAM_ADDR_BITS+1:2];
	assign rd_data = mem[word_addr];

	// Each request waits MEM_WAIT cycles, then completes in the cycle rw_wait drops.
	assign rw_wait = req && wait_cnt != 4'(MEM_WAIT);

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_cnt <= 4'd0;
			for (int i = 0; i < RAM_WORDS; i++)
				mem[i] <= 32'd0;
		end else begin
			if (rw_wait)
				wait_cnt <= wait_cnt + 4'd1;
			else
				wait_cnt <= 4'd0;
			if (wr_req && !rw_wait)
				mem[word_addr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- gp_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module gp_regfile (
	input  wire         clk,
	input  wire         reset,
	input  wire         write_reg,
	input  wire [3:0]   write_num,
	input  wire [31:0]  write_data,
	input  wire [3:0]   st_read,
	output logic [31:0] st_data
);

	logic [31:0] regs [16];

	// Store data is read without a cycle of delay.
	assign st_data = regs[st_read];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= 32'd0;
		end else if (write_reg) begin
			regs[write_num] <= write_data;
		end
	end

endmodule

`default_nettype wire

//--- sys_coproc.sv
`timescale 1ns/1ns
`default_nettype none

module sys_coproc (
	input  wire         clk,
	input  wire         reset,
	input  wire         cp_req,
	input  wire         cp_rnw,
	input  wire [3:0]   cp_num,
	input  wire [3:0]   cp_reg,
	input  wire [31:0]  cp_write,
	output logic        cp_ack,
	output logic        cp_busy,
	output logic [31:0] cp_read
);
	import arm_mem_pkg::*;

	logic [31:0] regs [16];
	logic        held;

	assign cp_ack = cp_num == CP_OWN_NUM;
	assign cp_read = regs[cp_reg];

	// Busy in the first cycle of a request; the next cycle finishes it.
	assign cp_busy = cp_req & ~held;

	always_ff @(posedge clk) begin
		if (reset) begin
			held <= 1'b0;
			for (int i = 0; i < 16; i++)
				regs[i] <= 32'd0;
		end else begin
			held <= cp_busy;
			if (cp_req && !cp_busy && cp_ack && !cp_rnw)
				regs[cp_reg] <= cp_write;
		end
	end

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "insn_decode_class.svh"

module mem_stage (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     inbubble,
	input  wire [31:0]              pc,
	input  wire arm_mem_pkg::insn_word_t insn,
	input  wire [31:0]              op0,
	input  wire [31:0]              op1,
	input  wire [31:0]              op2,
	input  wire [31:0]              spsr,
	input  wire [31:0]              cpsr,
	input  wire                     write_reg,
	input  wire [3:0]               write_num,
	input  wire [31:0]              write_data,
	output logic [31:0]             busaddr,
	output logic                    rd_req,
	output logic                    wr_req,
	output logic [31:0]             wr_data,
	input  wire [31:0]              rd_data,
	input  wire                     rw_wait,
	output logic [3:0]              st_read,
	input  wire [31:0]              st_data,
	output logic                    cp_req,
	input  wire                     cp_ack,
	input  wire                     cp_busy,
	output logic                    cp_rnw,
	input  wire [31:0]              cp_read,
	output logic [31:0]             cp_write,
	output logic [3:0]              cp_num,
	output logic [3:0]              cp_reg,
	output logic                    outstall,
	output logic                    outbubble,
	output logic [31:0]             outpc,
	output arm_mem_pkg::insn_word_t outinsn,
	output logic                    out_write_reg,
	output logic [3:0]              out_write_num,
	output logic [31:0]             out_write_data,
	output logic [31:0]             out_spsr,
	output logic [31:0]             out_cpsr
);
	import arm_mem_pkg::*;

	single_xfer_t sx;
	block_xfer_t  bx;
	logic         is_swp;
	logic         is_single;
	logic         is_block;
	logic         is_cpmove;
	logic         single_state;
	logic         next_single_state;
	logic         swp_state;
	logic         next_swp_state;
	logic [1:0]   blk_state;
	logic [1:0]   next_blk_state;
	logic [31:0]  swp_oldval;
	logic [31:0]  addr;
	logic [31:0]  raddr;
	logic [31:0]  blk_addr;
	logic [31:0]  store_data;
	logic [31:0]  aligned;
	logic [1:0]   align_addr;
	logic         single_wb;
	logic         next_outbubble;
	logic         next_write_reg;
	logic [3:0]   next_write_num;
	logic [31:0]  next_write_data;
	logic [31:0]  next_outcpsr;
	logic         walk_start;
	logic         walk_step;
	logic         walk_pre;
	logic         walk_last;
	logic [3:0]   walk_reg;
	logic [5:0]   walk_offset;

	assign sx = insn.single_view;
	assign bx = insn.block_view;

	always_comb begin
		is_swp = 1'b0;
		is_single = 1'b0;
		is_block = 1'b0;
		is_cpmove = 1'b0;
		casez (insn)
		`DECODE_SWP: is_swp = 1'b1;
		`DECODE_LDRSTR: is_single = 1'b1;
		`DECODE_LDMSTM: is_block = 1'b1;
		`DECODE_MRCMCR: is_cpmove = 1'b1;
		default: ;
		endcase
	end

	// Post-indexed transfers always write the base back.
	assign single_wb = sx.w | ~sx.p;
	assign addr = sx.u ? op0 + op1 : op0 - op1;
	assign raddr = sx.p ? addr : op0;
	assign blk_addr = bx.u ? op0 + {26'd0, walk_offset} : op0 - {26'd0, walk_offset};
	assign store_data = sx.b ? {4{op2[7:0]}} : op2;
	assign align_addr = is_swp ? op0[1:0] : raddr[1:0];

	assign walk_start = is_block && !inbubble && blk_state == BLK_SETUP;
	assign walk_step = is_block && !inbubble && blk_state == BLK_XFER && !rw_wait;
	// The base writeback needs the plain count, so pre-indexing only applies to accesses.
	assign walk_pre = bx.p && blk_state == BLK_XFER;

	load_align load_align_i (
		.rd_data(rd_data),
		.byte_addr(align_addr),
		.byte_sel(sx.b),
		.aligned(aligned)
	);

	reg_list_walker reg_list_walker_i (
		.clk(clk),
		.reset(reset),
		.start(walk_start),
		.step(walk_step),
		.descending(~bx.u),
		.pre_index(walk_pre),
		.reg_list(op1[15:0]),
		.cur_reg(walk_reg),
		.offset(walk_offset),
		.last(walk_last)
	);

	always_comb begin
		busaddr = {raddr[31:2], 2'b00};
		rd_req = 1'b0;
		wr_req = 1'b0;
		wr_data = store_data;
		st_read = walk_reg;
		cp_req = 1'b0;
		cp_rnw = sx.l;
		cp_write = op0;
		cp_num = sx.offset[CP_NUM_MSB:CP_NUM_LSB];
		cp_reg = sx.rn;
		outstall = 1'b0;
		next_outbubble = inbubble;
		next_write_reg = write_reg;
		next_write_num = write_num;
		next_write_data = write_data;
		next_outcpsr = cpsr;
		next_single_state = single_state;
		next_swp_state = swp_state;
		next_blk_state = blk_state;
		if (!inbubble) begin
			if (is_swp) begin
				next_write_reg = 1'b0;
				busaddr = {op0[31:2], 2'b00};
				if (swp_state == SEQ_FIRST) begin
					rd_req = 1'b1;
					outstall = 1'b1;
					if (!rw_wait)
						next_swp_state = SEQ_SECOND;
				end else begin
					wr_req = 1'b1;
					outstall = rw_wait;
					if (!rw_wait) begin
						next_write_reg = 1'b1;
						next_write_num = sx.rd;
						next_write_data = swp_oldval;
						next_swp_state = SEQ_FIRST;
					end
				end
			end else if (is_single) begin
				next_write_reg = 1'b0;
				if (single_state == SEQ_FIRST) begin
					rd_req = sx.l;
					wr_req = ~sx.l;
					outstall = rw_wait | single_wb;
					if (!rw_wait) begin
						next_write_reg = sx.l;
						next_write_num = sx.rd;
						next_write_data = aligned;
						if (single_wb)
							next_single_state = SEQ_SECOND;
					end
				end else begin
					next_write_reg = 1'b1;
					next_write_num = sx.rn;
					next_write_data = addr;
					next_single_state = SEQ_FIRST;
				end
			end else if (is_block) begin
				next_write_reg = 1'b0;
				busaddr = {blk_addr[31:2], 2'b00};
				wr_data = st_data;
				case (blk_state)
				BLK_SETUP: begin
					outstall = 1'b1;
					next_blk_state = BLK_XFER;
				end
				BLK_XFER: begin
					rd_req = bx.l;
					wr_req = ~bx.l;
					outstall = 1'b1;
					// Keep a status copied from spsr until the instruction retires.
					next_outcpsr = out_cpsr;
					if (!rw_wait) begin
						next_write_reg = bx.l;
						next_write_num = walk_reg;
						next_write_data = rd_data;
						if (bx.l && bx.s && walk_reg == PC_REG)
							next_outcpsr = spsr;
						if (walk_last)
							next_blk_state = BLK_BASE;
					end
				end
				default: begin
					next_outcpsr = out_cpsr;
					next_write_reg = bx.w;
					next_write_num = bx.rn;
					next_write_data = blk_addr;
					next_blk_state = BLK_SETUP;
				end
				endcase
			end else if (is_cpmove) begin
				next_write_reg = 1'b0;
				cp_req = 1'b1;
				outstall = cp_busy;
				if (!cp_busy && cp_ack && sx.l) begin
					// An MRC to r15 only updates the condition flags.
					if (sx.rd == PC_REG) begin
						next_outcpsr = {cp_read[FLAGS_MSB:FLAGS_LSB], cpsr[FLAGS_LSB-1:0]};
					end else begin
						next_write_reg = 1'b1;
						next_write_num = sx.rd;
						next_write_data = cp_read;
					end
				end
			end
			next_outbubble = outstall;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outbubble <= 1'b1;
			out_write_reg <= 1'b0;
			single_state <= SEQ_FIRST;
			swp_state <= SEQ_FIRST;
			blk_state <= BLK_SETUP;
		end else begin
			outbubble <= next_outbubble;
			out_write_reg <= next_write_reg;
			single_state <= next_single_state;
			swp_state <= next_swp_state;
			blk_state <= next_blk_state;
		end
	end

	always_ff @(posedge clk) begin
		outpc <= pc;
		outinsn <= insn;
		out_write_num <= next_write_num;
		out_write_data <= next_write_data;
		out_spsr <= spsr;
		out_cpsr <= next_outcpsr;
		if (!inbubble && is_swp && swp_state == SEQ_FIRST && !rw_wait)
			swp_oldval <= aligned;
	end

endmodule

`default_nettype wire

//--- mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     inbubble,
	input  wire [31:0]              pc,
	input  wire arm_mem_pkg::insn_word_t insn,
	input  wire [31:0]              op0,
	input  wire [31:0]              op1,
	input  wire [31:0]              op2,
	input  wire [31:0]              spsr,
	input  wire [31:0]              cpsr,
	input  wire                     write_reg,
	input  wire [3:0]               write_num,
	input  wire [31:0]              write_data,
	output wire                     outstall,
	output wire                     outbubble,
	output wire [31:0]              outpc,
	output arm_mem_pkg::insn_word_t outinsn,
	output wire                     out_write_reg,
	output wire [3:0]               out_write_num,
	output wire [31:0]              out_write_data,
	output wire [31:0]              out_spsr,
	output wire [31:0]              out_cpsr
);

	wire [31:0] busaddr;
	wire        rd_req;
	wire        wr_req;
	wire [31:0] wr_data;
	wire [31:0] rd_data;
	wire        rw_wait;
	wire [3:0]  st_read;
	wire [31:0] st_data;
	wire        cp_req;
	wire        cp_ack;
	wire        cp_busy;
	wire        cp_rnw;
	wire [31:0] cp_read;
	wire [31:0] cp_write;
	wire [3:0]  cp_num;
	wire [3:0]  cp_reg;

	mem_stage mem_stage_i (.*);

	data_ram data_ram_i (.*);

	// The register file takes the stage's registered writeback, not the upstream one.
	gp_regfile gp_regfile_i (
		.*,
		.write_reg(out_write_reg),
		.write_num(out_write_num),
		.write_data(out_write_data)
	);

	sys_coproc sys_coproc_i (.*);

endmodule

`default_nettype wire

//--- mem_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "insn_decode_class.svh"

module mem_subsys_tb;
	import arm_mem_pkg::*;

	localparam logic [31:0] BASE_SPSR = 32'h6000_0010;
	localparam logic [31:0] BASE_CPSR = 32'h1000_00d3;

	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] op0;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] spsr;
		logic [31:0] cpsr;
	} row_t;

	logic        clk;
	logic        reset;
	logic        inbubble;
	logic [31:0] pc;
	logic [31:0] insn;
	logic [31:0] op0;
	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] spsr;
	logic [31:0] cpsr;
	logic        write_reg;
	logic [3:0]  write_num;
	logic [31:0] write_data;
	wire         outstall;
	wire         outbubble;
	wire  [31:0] outpc;
	wire  [31:0] outinsn;
	wire         out_write_reg;
	wire  [3:0]  out_write_num;
	wire  [31:0] out_write_data;
	wire  [31:0] out_spsr;
	wire  [31:0] out_cpsr;

	row_t        rows[$];
	logic [3:0]  exp_num[$];
	logic [31:0] exp_data[$];
	logic [31:0] exp_cpsr;
	logic [31:0] mem_model[256];
	logic [31:0] reg_model[16];
	logic [31:0] cp_model[16];
	logic        stall_q = 1'b0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	mem_subsys_top mem_subsys_top_i (.*);

	// Flags are given as P U B W L.
	function automatic logic [31:0] ldr_str_word(input logic [4:0] flags, input logic [3:0] rn,
			input logic [3:0] rd, input logic [11:0] off);
		return {4'he, 3'b010, flags, rn, rd, off};
	endfunction

	function automatic logic [31:0] swp_word(input logic b, input logic [3:0] rn,
			input logic [3:0] rd, input logic [3:0] rm);
		return {4'he, 5'b00010, b, 2'b00, rn, rd, 4'b0000, 4'b1001, rm};
	endfunction

	// Flags are given as P U S W L.
	function automatic logic [31:0] ldm_stm_word(input logic [4:0] flags, input logic [3:0] rn,
			input logic [15:0] list);
		return {4'he, 3'b100, flags, rn, list};
	endfunction

	function automatic logic [31:0] mcr_mrc_word(input logic l, input logic [3:0] crn,
			input logic [3:0] rd, input logic [3:0] num);
		return {4'he, 4'b1110, 3'b000, l, crn, rd, num, 3'b000, 1'b1, 4'b0000};
	endfunction

	// A load rotates the word right by the byte address, and a byte load keeps the low byte.
	function automatic logic [31:0] loaded_value(input logic [31:0] word, input logic [1:0] a,
			input logic byte_load);
		logic [63:0] both;
		logic [31:0] rot;
		both = {word, word};
		rot = both[int'(a) * 8 +: 32];
		return byte_load ? {24'd0, rot[7:0]} : rot;
	endfunction

	task automatic add_row(input logic [31:0] i, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] c);
		rows.push_back('{i, a, b, c, BASE_SPSR, BASE_CPSR});
	endtask

	task automatic expect_write(input logic [3:0] num, input logic [31:0] data);
		exp_num.push_back(num);
		exp_data.push_back(data);
		reg_model[num] = data;
	endtask

	task automatic predict(input int k);
		row_t         r;
		single_xfer_t sv;
		block_xfer_t  bv;
		logic [31:0]  moved;
		logic [31:0]  ea;
		logic [31:0]  off;
		logic [3:0]   idx;
		logic         known;
		int           n;
		r = rows[k];
		sv = r.insn;
		bv = r.insn;
		known = 1'b1;
		n = 0;
		exp_cpsr = r.cpsr;
		casez (r.insn)
		`DECODE_SWP: begin
			moved = loaded_value(mem_model[r.op0[9:2]], r.op0[1:0], sv.b);
			mem_model[r.op0[9:2]] = sv.b ? {4{r.op2[7:0]}} : r.op2;
			expect_write(sv.rd, moved);
		end
		`DECODE_LDRSTR: begin
			moved = sv.u ? r.op0 + r.op1 : r.op0 - r.op1;
			ea = sv.p ? moved : r.op0;
			if (sv.l)
				expect_write(sv.rd, loaded_value(mem_model[ea[9:2]], ea[1:0], sv.b));
			else
				mem_model[ea[9:2]] = sv.b ? {4{r.op2[7:0]}} : r.op2;
			if (sv.w || !sv.p)
				expect_write(sv.rn, moved);
		end
		`DECODE_LDMSTM: begin
			for (int j = 0; j < 16; j++) begin
				idx = bv.u ? 4'(j) : 4'(15 - j);
				if (r.op1[idx]) begin
					off = 32'(4 * (n + int'(bv.p)));
					ea = bv.u ? r.op0 + off : r.op0 - off;
					if (bv.l) begin
						expect_write(idx, mem_model[ea[9:2]]);
						if (bv.s && idx == PC_REG)
							exp_cpsr = r.spsr;
					end else begin
						mem_model[ea[9:2]] = reg_model[idx];
					end
					n++;
				end
			end
			off = 32'(4 * n);
			if (bv.w)
				expect_write(bv.rn, bv.u ? r.op0 + off : r.op0 - off);
		end
		`DECODE_MRCMCR: begin
			if (sv.offset[11:8] == CP_OWN_NUM) begin
				if (!sv.l)
					cp_model[sv.rn] = r.op0;
				else if (sv.rd == PC_REG)
					exp_cpsr = {cp_model[sv.rn][FLAGS_MSB:FLAGS_LSB], r.cpsr[FLAGS_LSB-1:0]};
				else
					expect_write(sv.rd, cp_model[sv.rn]);
			end
		end
		default: known = 1'b0;
		endcase
		assert (known) else begin
			$display("table row %0d does not decode as a memory instruction", k);
			$display("TEST FAIL");
			$fatal(1, "undecodable table row");
		end
	endtask

	task automatic build_table();
		add_row(ldr_str_word(5'b11000, 4'd0, 4'd0, 12'd0), 32'h100, 32'h0, 32'h1122_3344);
		add_row(ldr_str_word(5'b11000, 4'd0, 4'd0, 12'd4), 32'h100, 32'h4, 32'ha5b6_c7d8);
		add_row(ldr_str_word(5'b11100, 4'd0, 4'd0, 12'd8), 32'h100, 32'h8, 32'h0000_00c3);
		for (int a = 0; a < 4; a++) begin
			add_row(ldr_str_word(5'b11001, 4'd0, 4'(1 + a), 12'(a)), 32'h100, 32'(a), 32'h0);
			add_row(ldr_str_word(5'b11101, 4'd0, 4'(5 + a), 12'(a)), 32'h104, 32'(a), 32'h0);
		end
		add_row(ldr_str_word(5'b11001, 4'd0, 4'd9, 12'd8), 32'h100, 32'h8, 32'h0);
		// Pre-up and post-down stores, then pre-down and post-up loads of the same words.
		add_row(ldr_str_word(5'b11010, 4'd10, 4'd0, 12'h8), 32'h200, 32'h8, 32'hcafe_0001);
		add_row(ldr_str_word(5'b00000, 4'd11, 4'd0, 12'h10), 32'h220, 32'h10, 32'hcafe_0002);
		add_row(ldr_str_word(5'b10011, 4'd10, 4'd12, 12'h18), 32'h220, 32'h18, 32'h0);
		add_row(ldr_str_word(5'b01001, 4'd11, 4'd13, 12'h4), 32'h220, 32'h4, 32'h0);
		add_row(ldr_str_word(5'b11001, 4'd0, 4'd14, 12'h0), 32'h210, 32'h0, 32'h0);
		add_row(swp_word(1'b0, 4'd0, 4'd12, 4'd1), 32'h104, 32'h0, 32'h0bad_f00d);
		add_row(ldr_str_word(5'b11001, 4'd0, 4'd14, 12'd0), 32'h104, 32'h0, 32'h0);
		add_row(swp_word(1'b1, 4'd0, 4'd12, 4'd1), 32'h101, 32'h0, 32'h0000_005a);
		add_row(ldr_str_word(5'b11001, 4'd0, 4'd14, 12'd0), 32'h100, 32'h0, 32'h0);
		add_row(ldm_stm_word(5'b01010, 4'd0, 16'h002e), 32'h300, 32'h002e, 32'h0);
		add_row(ldm_stm_word(5'b01011, 4'd0, 16'h05c0), 32'h300, 32'h05c0, 32'h0);
		add_row(ldm_stm_word(5'b11011, 4'd0, 16'h0c00), 32'h2fc, 32'h0c00, 32'h0);
		add_row(ldm_stm_word(5'b10010, 4'd0, 16'h0212), 32'h380, 32'h0212, 32'h0);
		add_row(ldm_stm_word(5'b10011, 4'd0, 16'h080c), 32'h380, 32'h080c, 32'h0);
		add_row(ldm_stm_word(5'b00011, 4'd0, 16'h0060), 32'h37c, 32'h0060, 32'h0);
		add_row(ldm_stm_word(5'b01010, 4'd0, 16'hfffe), 32'h3c0, 32'hfffe, 32'h0);
		add_row(mcr_mrc_word(1'b0, 4'd3, 4'd0, CP_OWN_NUM), 32'h1357_9bdf, 32'h0, 32'h0);
		add_row(mcr_mrc_word(1'b1, 4'd3, 4'd7, CP_OWN_NUM), 32'h0, 32'h0, 32'h0);
		add_row(mcr_mrc_word(1'b0, 4'd5, 4'd0, CP_OWN_NUM), 32'ha5a5_0000, 32'h0, 32'h0);
		add_row(mcr_mrc_word(1'b1, 4'd5, PC_REG, CP_OWN_NUM), 32'h0, 32'h0, 32'h0);
		// Loading r15 with the S bit restores the saved status.
		add_row(ldm_stm_word(5'b01111, 4'd13, 16'h8001), 32'h3c0, 32'h8001, 32'h0);
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		stall_q <= outstall;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		assert (cycle_limit == 0 || cycle_count <= cycle_limit) else begin
			$display("the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	always @(posedge clk) begin
		if (!reset && out_write_reg) begin
			assert (exp_num.size() > 0) else begin
				$display("error %0t: unexpected writeback r%0d = %h", $time, out_write_num,
					out_write_data);
				$display("TEST FAIL");
				$fatal(1, "unexpected writeback");
			end
			assert (out_write_num == exp_num[0] && out_write_data == exp_data[0]) else begin
				$display("error %0t: writeback r%0d = %h, expected r%0d = %h", $time,
					out_write_num, out_write_data, exp_num[0], exp_data[0]);
				$display("TEST FAIL");
				$fatal(1, "writeback mismatch");
			end
			void'(exp_num.pop_front());
			void'(exp_data.pop_front());
		end
	end

	initial begin
		reset = 1'b1;
		inbubble = 1'b1;
		pc = 32'h0;
		insn = 32'h0;
		op0 = 32'h0;
		op1 = 32'h0;
		op2 = 32'h0;
		spsr = BASE_SPSR;
		cpsr = BASE_CPSR;
		write_reg = 1'b0;
		write_num = 4'd0;
		write_data = 32'h0;
		for (int i = 0; i < 256; i++)
			mem_model[i] = 32'h0;
		for (int i = 0; i < 16; i++) begin
			reg_model[i] = 32'h0;
			cp_model[i] = 32'h0;
		end
		build_table();
		cycle_limit = rows.size() * (16 * (MEM_WAIT + 1) + 4) + 20;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			assert (exp_num.size() == 0) else begin
				$display("%0d expected writebacks never appeared before row %0d",
					exp_num.size(), i);
				$display("TEST FAIL");
				$fatal(1, "missing writeback");
			end
			predict(i);
			inbubble = 1'b0;
			pc = 32'(4 * i);
			insn = rows[i].insn;
			op0 = rows[i].op0;
			op1 = rows[i].op1;
			op2 = rows[i].op2;
			spsr = rows[i].spsr;
			cpsr = rows[i].cpsr;
			do
				@(negedge clk);
			while (stall_q);
			assert (out_cpsr == exp_cpsr && !outbubble) else begin
				$display("error %0t: row %0d out_cpsr = %h outbubble = %b, expected %h and 0",
					$time, i, out_cpsr, outbubble, exp_cpsr);
				$display("TEST FAIL");
				$fatal(1, "status mismatch");
			end
			// The pc, instruction and saved status travel unchanged to the next stage.
			assert (outpc == 32'(4 * i) && outinsn == rows[i].insn
					&& out_spsr == rows[i].spsr) else begin
				$display("error %0t: row %0d outpc = %h outinsn = %h out_spsr = %h",
					$time, i, outpc, outinsn, out_spsr);
				$display("error %0t: row %0d expected %h %h %h", $time, i, 32'(4 * i),
					rows[i].insn, rows[i].spsr);
				$display("TEST FAIL");
				$fatal(1, "pass-through mismatch");
			end
			inbubble = 1'b1;
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		if (exp_num.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("%0d expected writebacks never appeared at the end", exp_num.size());
			$display("TEST FAIL");
			$fatal(1, "missing writeback");
		end
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
arm_mem_pkg.sv
load_align.sv
reg_list_walker.sv
data_ram.sv
gp_regfile.sv
sys_coproc.sv
mem_stage.sv
mem_subsys_top.sv
mem_subsys_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb \
	-f project.f -o mem_subsys_sim
./obj_dir/mem_subsys_sim
